// ==== core_top.f ====
+incdir+tests
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/core_top.sv
tests/core_tb.sv

// ==== tests/iss_model.svh ====
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// in-order reference state and the expected event queues
logic [31:0] model_regs [32];
logic [31:0] model_dmem [64];
logic [4:0]  exp_rd [$];
logic [31:0] exp_wdata [$];
logic [31:0] exp_saddr [$];
logic [31:0] exp_sdata [$];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

// branch offset is 13 bits with bit 0 implied zero
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
	return {{20{v[11]}}, v};
endfunction

// x0 writes leave no trace on the retire port
task automatic model_write(input logic [4:0] rd, input logic [31:0] val);
	if (rd != 5'd0) begin
		model_regs[rd] = val;
		exp_rd.push_back(rd);
		exp_wdata.push_back(val);
	end
endtask

task automatic run_model();
	int unsigned pc;
	int unsigned next_pc;
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] addr;
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
	for (int i = 0; i < 64; i++) begin
		model_dmem[i] = '0;
	end
	pc = 0;
	while (pc < PROG_LEN * 4) begin
		w = prog_mem[pc / 4];
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		next_pc = pc + 4;
		case (w[6:0])
			7'h33: begin
				case ({w[31:25], w[14:12]})
					{7'h00, 3'b000}: model_write(w[11:7], a + b);
					{7'h20, 3'b000}: model_write(w[11:7], a - b);
					{7'h00, 3'b111}: model_write(w[11:7], a & b);
					{7'h00, 3'b110}: model_write(w[11:7], a | b);
					{7'h00, 3'b100}: model_write(w[11:7], a ^ b);
					{7'h00, 3'b010}: model_write(w[11:7], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: ;
				endcase
			end
			7'h13: model_write(w[11:7], a + sext12(w[31:20]));
			7'h03: begin
				addr = a + sext12(w[31:20]);
				model_write(w[11:7], model_dmem[addr[7:2]]);
			end
			7'h23: begin
				addr = a + sext12({w[31:25], w[11:7]});
				model_dmem[addr[7:2]] = b;
				exp_saddr.push_back(addr);
				exp_sdata.push_back(b);
			end
			7'h63: begin
				if (a == b) begin
					next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			default: ;
		endcase
		pc = next_pc;
	end
endtask

`endif

// ==== tests/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

	localparam int PROG_LEN     = 200;
	localparam int MAX_CYCLES   = 4 * PROG_LEN + 100;
	// fetch this far past the program end means every real instruction has left
	localparam int DRAIN_ADDR   = PROG_LEN * 4 + 24;
	// first word fetched in cycle 1, reaches MEM in cycle 4 and WB in cycle 5
	localparam int FIRST_STORE  = 4;
	localparam int FIRST_RETIRE = 5;
	localparam logic [31:0] NOP_WORD = 32'h0000_0013;

	logic        clk;
	logic        rst_n;
	logic [31:0] instr_i;
	logic [31:0] imem_addr_o;
	logic        retire_valid_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_data_o;
	logic        store_valid_o;
	logic [31:0] store_addr_o;
	logic [31:0] store_data_o;

	logic [31:0] prog_mem [PROG_LEN];
	integer      seed;
	int          mismatch_count;
	int          other_count;
	int          retire_count;
	int          store_count;
	int          cycles;
	bit          done;

	`include "iss_model.svh"

	core_top dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_i       (instr_i),
		.imem_addr_o   (imem_addr_o),
		.retire_valid_o(retire_valid_o),
		.retire_rd_o   (retire_rd_o),
		.retire_data_o (retire_data_o),
		.store_valid_o (store_valid_o),
		.store_addr_o  (store_addr_o),
		.store_data_o  (store_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// NOP outside the program
	function automatic logic [31:0] imem_read(input logic [31:0] addr);
		logic [31:0] word;
		if (addr < PROG_LEN * 4) begin
			word = prog_mem[addr[31:2]];
		end else begin
			word = NOP_WORD;
		end
		return word;
	endfunction

	always @(posedge clk) begin
		#1;
		instr_i = imem_read(imem_addr_o);
	end

	// registers x0..x7 only, so hazards show up often
	task automatic gen_program();
		int kind;
		int off;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		for (int i = 0; i < PROG_LEN; i++) begin
			kind = $unsigned($random(seed)) % 14;
			rd   = $unsigned($random(seed)) % 8;
			rs1  = $unsigned($random(seed)) % 8;
			rs2  = $unsigned($random(seed)) % 8;
			off  = 4 * ($unsigned($random(seed)) % 64);
			case (kind)
				0: prog_mem[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
				1: prog_mem[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
				2: prog_mem[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
				3: prog_mem[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
				4: prog_mem[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
				5: prog_mem[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
				6, 7: prog_mem[i] = enc_i($random(seed), rs1, 3'b000, rd, 7'h13);
				8, 9: prog_mem[i] = enc_i(off[11:0], 5'd0, 3'b010, rd, 7'h03);
				10, 11: prog_mem[i] = enc_s(off[11:0], rs2, 5'd0);
				default: begin
					// equal sources half the time so many branches are taken
					if ($random(seed) & 1) begin
						rs2 = rs1;
					end
					off = 8 + 4 * ($unsigned($random(seed)) % 5);
					prog_mem[i] = enc_b(off[12:0], rs2, rs1);
				end
			endcase
		end
	endtask

	task automatic report_mismatch(input string name, input int idx,
		input logic [31:0] exp_v, input logic [31:0] act_v);
		mismatch_count++;
		$display("Mismatch %s #%0d: expected %h, actual %h", name, idx, exp_v, act_v);
	endtask

	task automatic check_events();
		logic [4:0]  e_rd;
		logic [31:0] e_val;
		logic [31:0] e_addr;
		if (retire_valid_o) begin
			if (cycles < FIRST_RETIRE) begin
				other_count++;
				$display("retire pulse %0d cycles after reset, before any instruction could retire",
					cycles);
			end
			if (exp_rd.size() == 0) begin
				other_count++;
				$display("retire of x%0d = %h arrived but the model expects no more register writes",
					retire_rd_o, retire_data_o);
			end else begin
				e_rd  = exp_rd.pop_front();
				e_val = exp_wdata.pop_front();
				if (retire_rd_o != e_rd) begin
					report_mismatch("retire rd", retire_count, e_rd, retire_rd_o);
				end
				if (retire_data_o != e_val) begin
					report_mismatch("retire data", retire_count, e_val, retire_data_o);
				end
			end
			retire_count++;
		end
		if (store_valid_o) begin
			if (cycles < FIRST_STORE) begin
				other_count++;
				$display("store pulse %0d cycles after reset, before any store could reach memory",
					cycles);
			end
			if (exp_saddr.size() == 0) begin
				other_count++;
				$display("store to %h arrived but the model expects no more stores", store_addr_o);
			end else begin
				e_addr = exp_saddr.pop_front();
				e_val  = exp_sdata.pop_front();
				if (store_addr_o != e_addr) begin
					report_mismatch("store addr", store_count, e_addr, store_addr_o);
				end
				if (store_data_o != e_val) begin
					report_mismatch("store data", store_count, e_val, store_data_o);
				end
			end
			store_count++;
		end
	endtask

	initial begin
		seed           = 79602;
		rst_n          = 1'b0;
		instr_i        = NOP_WORD;
		mismatch_count = 0;
		other_count    = 0;
		retire_count   = 0;
		store_count    = 0;
		cycles         = 0;
		done           = 1'b0;
		gen_program();
		run_model();
		$display("model expects %0d register writes and %0d stores",
			exp_rd.size(), exp_saddr.size());

		repeat (10) begin
			@(negedge clk);
			if (retire_valid_o || store_valid_o) begin
				other_count++;
				$display("retire or store pulse seen while reset is asserted");
			end
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;

		while (!done && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
			check_events();
			done = exp_rd.size() == 0 && exp_saddr.size() == 0 && imem_addr_o >= DRAIN_ADDR;
		end
		if (!done) begin
			other_count++;
			$display("timeout after %0d cycles with %0d retires and %0d stores still expected",
				cycles, exp_rd.size(), exp_saddr.size());
		end

		$display("errors: %0d mismatches, %0d other (%0d retires, %0d stores checked)",
			mismatch_count, other_count, retire_count, store_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/1ps

module core_top
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic [XLEN-1:0] instr_i,
	output logic [XLEN-1:0] imem_addr_o,
	output logic            retire_valid_o,
	output logic [4:0]      retire_rd_o,
	output logic [XLEN-1:0] retire_data_o,
	output logic            store_valid_o,
	output logic [XLEN-1:0] store_addr_o,
	output logic [XLEN-1:0] store_data_o
);

	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	mem_wb_t         mem_wb;
	logic            stall;
	logic            flush;
	logic [XLEN-1:0] branch_target;

	fetch_stage fetch_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.stall_i        (stall),
		.flush_i        (flush),
		.branch_target_i(branch_target),
		.instr_i        (instr_i),
		.imem_addr_o    (imem_addr_o),
		.if_id_o        (if_id)
	);

	decode_stage decode_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.if_id_i (if_id),
		.flush_i (flush),
		.mem_wb_i(mem_wb),
		.stall_o (stall),
		.id_ex_o (id_ex)
	);

	execute_stage execute_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_ex_i        (id_ex),
		.mem_wb_i       (mem_wb),
		.flush_o        (flush),
		.branch_target_o(branch_target),
		.ex_mem_o       (ex_mem)
	);

	mem_stage mem_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_mem_i     (ex_mem),
		.store_valid_o(store_valid_o),
		.store_addr_o (store_addr_o),
		.store_data_o (store_data_o),
		.mem_wb_o     (mem_wb)
	);

	// retire on the same cycle the register file takes the write
	assign retire_valid_o = mem_wb.valid && mem_wb.reg_we && mem_wb.rd != 5'd0;
	assign retire_rd_o    = mem_wb.rd;
	assign retire_data_o  = mem_wb.wb_val;

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  ex_mem_t         ex_mem_i,
	output logic            store_valid_o,
	output logic [XLEN-1:0] store_addr_o,
	output logic [XLEN-1:0] store_data_o,
	output mem_wb_t         mem_wb_o
);

	logic [XLEN-1:0]    dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] word_idx;
	logic [XLEN-1:0]    load_word;

	// word index from address bits 7:2
	assign word_idx  = ex_mem_i.alu_res[DMEM_AW+1:2];
	assign load_word = dmem[word_idx];

	assign store_valid_o = ex_mem_i.valid && ex_mem_i.ctrl.mem_we;
	assign store_addr_o  = ex_mem_i.alu_res;
	assign store_data_o  = ex_mem_i.store_val;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (store_valid_o) begin
			dmem[word_idx] <= ex_mem_i.store_val;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb_o <= '0;
		end else begin
			mem_wb_o.valid  <= ex_mem_i.valid;
			mem_wb_o.reg_we <= ex_mem_i.valid && ex_mem_i.ctrl.reg_we;
			mem_wb_o.rd     <= ex_mem_i.rd;
			mem_wb_o.wb_val <= ex_mem_i.ctrl.mem_to_reg ? load_word : ex_mem_i.alu_res;
		end
	end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  id_ex_t          id_ex_i,
	input  mem_wb_t         mem_wb_i,
	output logic            flush_o,
	output logic [XLEN-1:0] branch_target_o,
	output ex_mem_t         ex_mem_o
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] fwd_b;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;

	// EX/MEM first (never a load), then MEM/WB, then the register value
	function automatic logic [XLEN-1:0] fwd_sel(input logic [4:0] rs,
		input logic [XLEN-1:0] reg_val);
		logic [XLEN-1:0] val;
		if (rs != 5'd0 && ex_mem_o.valid && ex_mem_o.ctrl.reg_we &&
			!ex_mem_o.ctrl.mem_re && ex_mem_o.rd == rs) begin
			val = ex_mem_o.alu_res;
		end else if (rs != 5'd0 && mem_wb_i.valid && mem_wb_i.reg_we &&
			mem_wb_i.rd == rs) begin
			val = mem_wb_i.wb_val;
		end else begin
			val = reg_val;
		end
		return val;
	endfunction

	always_comb begin
		op_a  = fwd_sel(id_ex_i.rs1, id_ex_i.rs1_val);
		fwd_b = fwd_sel(id_ex_i.rs2, id_ex_i.rs2_val);
	end

	assign op_b = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : fwd_b;

	always_comb begin
		case (id_ex_i.ctrl.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_res = '0;
		endcase
	end

	// taken BEQ redirects fetch and kills the two younger slots
	assign flush_o         = id_ex_i.valid && id_ex_i.ctrl.is_branch && (op_a == fwd_b);
	assign branch_target_o = id_ex_i.pc + id_ex_i.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_o <= '0;
		end else begin
			ex_mem_o.valid     <= id_ex_i.valid;
			ex_mem_o.ctrl      <= id_ex_i.ctrl;
			ex_mem_o.rd        <= id_ex_i.rd;
			ex_mem_o.alu_res   <= alu_res;
			ex_mem_o.store_val <= fwd_b;
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
	import rv_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  if_id_t  if_id_i,
	input  logic    flush_i,
	input  mem_wb_t mem_wb_i,
	output logic    stall_o,
	output id_ex_t  id_ex_o
);

	rv_instr_u       ins;
	logic [6:0]      opcode;
	ctrl_t           ctrl;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;

	assign ins    = if_id_i.instr;
	assign opcode = ins.r_fmt.opcode;

	reg_file reg_file_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_i    (ins.r_fmt.rs1),
		.rs2_i    (ins.r_fmt.rs2),
		.rs1_val_o(rs1_val),
		.rs2_val_o(rs2_val),
		.we_i     (mem_wb_i.valid && mem_wb_i.reg_we),
		.rd_i     (mem_wb_i.rd),
		.wdata_i  (mem_wb_i.wb_val)
	);

	// unsupported encodings keep ctrl at zero and become bubbles
	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_we = 1'b1;
				if (ins.r_fmt.funct7 == F7_SUB && ins.r_fmt.funct3 == F3_ADD) begin
					ctrl.alu_op = ALU_SUB;
				end else if (ins.r_fmt.funct7 == F7_BASE) begin
					case (ins.r_fmt.funct3)
						F3_ADD:  ctrl.alu_op = ALU_ADD;
						F3_SLT:  ctrl.alu_op = ALU_SLT;
						F3_XOR:  ctrl.alu_op = ALU_XOR;
						F3_OR:   ctrl.alu_op = ALU_OR;
						F3_AND:  ctrl.alu_op = ALU_AND;
						default: ctrl.reg_we = 1'b0;
					endcase
				end else begin
					ctrl.reg_we = 1'b0;
				end
			end
			OP_ITYPE: begin
				ctrl.reg_we      = (ins.i_fmt.funct3 == F3_ADD);
				ctrl.alu_src_imm = 1'b1;
			end
			OP_LOAD: begin
				ctrl.reg_we      = (ins.i_fmt.funct3 == F3_LW);
				ctrl.mem_re      = (ins.i_fmt.funct3 == F3_LW);
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			OP_STORE: begin
				ctrl.mem_we      = (ins.s_fmt.funct3 == F3_SW);
				ctrl.alu_src_imm = 1'b1;
			end
			OP_BRANCH: begin
				ctrl.is_branch = (ins.b_fmt.funct3 == F3_BEQ);
				ctrl.alu_op    = ALU_SUB;
			end
			default: ctrl = '0;
		endcase
	end

	// immediate layout picked by format
	always_comb begin
		case (opcode)
			OP_STORE:  imm = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
			OP_BRANCH: imm = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
				ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
			default:   imm = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
		endcase
	end

	// load in EX feeding the instruction in ID
	assign stall_o = if_id_i.valid && id_ex_o.valid && id_ex_o.ctrl.mem_re &&
		id_ex_o.rd != 5'd0 &&
		(id_ex_o.rd == ins.r_fmt.rs1 || id_ex_o.rd == ins.r_fmt.rs2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_o <= '0;
		end else if (flush_i || stall_o) begin
			id_ex_o <= '0;
		end else begin
			id_ex_o.valid   <= if_id_i.valid;
			id_ex_o.pc      <= if_id_i.pc;
			id_ex_o.ctrl    <= ctrl;
			id_ex_o.rs1     <= ins.r_fmt.rs1;
			id_ex_o.rs2     <= ins.r_fmt.rs2;
			id_ex_o.rd      <= ins.r_fmt.rd;
			id_ex_o.rs1_val <= rs1_val;
			id_ex_o.rs2_val <= rs2_val;
			id_ex_o.imm     <= imm;
		end
	end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic [4:0]      rs1_i,
	input  logic [4:0]      rs2_i,
	output logic [XLEN-1:0] rs1_val_o,
	output logic [XLEN-1:0] rs2_val_o,
	input  logic            we_i,
	input  logic [4:0]      rd_i,
	input  logic [XLEN-1:0] wdata_i
);

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= wdata_i;
		end
	end

	// same-cycle write is visible to the reader
	function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr);
		logic [XLEN-1:0] val;
		if (addr == 5'd0) begin
			val = '0;
		end else if (we_i && addr == rd_i) begin
			val = wdata_i;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		rs1_val_o = read_reg(rs1_i);
		rs2_val_o = read_reg(rs2_i);
	end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall_i,
	input  logic            flush_i,
	input  logic [XLEN-1:0] branch_target_i,
	input  logic [XLEN-1:0] instr_i,
	output logic [XLEN-1:0] imem_addr_o,
	output if_id_t          if_id_o
);

	logic [XLEN-1:0] pc;

	assign imem_addr_o = pc;

	// flush wins over stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (flush_i) begin
			pc <= branch_target_i;
		end else if (!stall_i) begin
			pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id_o <= '0;
		end else if (flush_i) begin
			// wrong-path word is dropped
			if_id_o.valid <= 1'b0;
		end else if (!stall_i) begin
			if_id_o.valid <= 1'b1;
			if_id_o.pc    <= pc;
			if_id_o.instr <= instr_i;
		end
	end

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

	localparam int XLEN       = 32;
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// base opcodes of the supported subset
	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_SW  = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	// one instruction word, four field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
	} rv_instr_u;

	typedef struct packed {
		logic    reg_we;
		logic    mem_re;
		logic    mem_we;
		logic    mem_to_reg;
		logic    is_branch;
		logic    alu_src_imm;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		rv_instr_u       instr;
	} if_id_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		ctrl_t           ctrl;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
		logic [XLEN-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		logic            valid;
		ctrl_t           ctrl;
		logic [4:0]      rd;
		logic [XLEN-1:0] alu_res;
		logic [XLEN-1:0] store_val;
	} ex_mem_t;

	typedef struct packed {
		logic            valid;
		logic            reg_we;
		logic [4:0]      rd;
		logic [XLEN-1:0] wb_val;
	} mem_wb_t;

endpackage
